//--- zynq_pl_irq_pkg.sv
// Widths, register offsets, response codes and block identification for the PL interrupt block
`default_nettype none

package zynq_pl_irq_pkg;

    // Interrupt lines and stretch length
    localparam int irq_count       = 8;
    localparam int irq_stretch_len = 10;

    // AXI-lite control port
    localparam int axil_addr_width = 8;
    localparam int axil_data_width = 32;
    localparam int axil_strb_width = axil_data_width / 8;

    localparam int timer_width = 16;

    // Register map
    localparam logic [axil_addr_width-1:0] reg_irq_enable   = 8'h00;
    localparam logic [axil_addr_width-1:0] reg_irq_pending  = 8'h04;
    localparam logic [axil_addr_width-1:0] reg_irq_force    = 8'h08;
    localparam logic [axil_addr_width-1:0] reg_timer_period = 8'h0C;
    localparam logic [axil_addr_width-1:0] reg_timer_ctrl   = 8'h10;
    localparam logic [axil_addr_width-1:0] reg_block_id     = 8'h14;

    // Read-only identification word
    localparam logic [axil_data_width-1:0] block_id_value = 32'h4952_5101;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

endpackage

`default_nettype wire

//--- irq_ctrl_if.sv
// Register state interface between the AXI-lite control slave and the event generator
`timescale 1ns/1ps
`default_nettype none

interface irq_ctrl_if
    import zynq_pl_irq_pkg::*;
;

    // Driven by the register block
    logic [irq_count-1:0]   irq_enable;
    logic [irq_count-1:0]   clear_mask;
    logic [irq_count-1:0]   force_mask;
    logic [timer_width-1:0] timer_period;
    logic                   timer_enable;

    // Driven by the event generator
    logic [irq_count-1:0]   pending;

    modport regs (
        output irq_enable,
        output clear_mask,
        output force_mask,
        output timer_period,
        output timer_enable,
        input  pending
    );

    modport gen (
        input  irq_enable,
        input  clear_mask,
        input  force_mask,
        input  timer_period,
        input  timer_enable,
        output pending
    );

endinterface

`default_nettype wire

//--- axil_ctrl_regs.sv
// AXI-lite control slave with enable, pending, force, timer and identification registers
`timescale 1ns/1ps
`default_nettype none

module axil_ctrl_regs
    import zynq_pl_irq_pkg::*;
(
    input  logic                       zynq_pl_clk,
    input  logic                       zynq_pl_reset,

    input  logic [axil_addr_width-1:0] s_axil_awaddr,
    input  logic                       s_axil_awvalid,
    output logic                       s_axil_awready,
    input  logic [axil_data_width-1:0] s_axil_wdata,
    input  logic [axil_strb_width-1:0] s_axil_wstrb,
    input  logic                       s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic [1:0]                 s_axil_bresp,
    output logic                       s_axil_bvalid,
    input  logic                       s_axil_bready,

    input  logic [axil_addr_width-1:0] s_axil_araddr,
    input  logic                       s_axil_arvalid,
    output logic                       s_axil_arready,
    output logic [axil_data_width-1:0] s_axil_rdata,
    output logic [1:0]                 s_axil_rresp,
    output logic                       s_axil_rvalid,
    input  logic                       s_axil_rready,

    irq_ctrl_if.regs                   ctrl
);

    logic                       wr_accept;
    logic                       rd_accept;
    logic [axil_data_width-1:0] rd_word;
    logic [1:0]                 rd_resp;

    // Address and data taken together, one response outstanding
    assign wr_accept      = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_accept;
    assign s_axil_wready  = wr_accept;

    assign rd_accept = s_axil_arvalid && s_axil_arready;

    // Write decode and response
    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            s_axil_bvalid     <= 1'b0;
            s_axil_bresp      <= resp_okay;
            ctrl.irq_enable   <= '0;
            ctrl.clear_mask   <= '0;
            ctrl.force_mask   <= '0;
            ctrl.timer_period <= '0;
            ctrl.timer_enable <= 1'b0;
        end else begin
            // Clear and force are single-cycle strobes
            ctrl.clear_mask <= '0;
            ctrl.force_mask <= '0;

            if (s_axil_bvalid && s_axil_bready) begin
                s_axil_bvalid <= 1'b0;
            end

            if (wr_accept) begin
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= resp_okay;
                case (s_axil_awaddr)
                    reg_irq_enable: begin
                        if (s_axil_wstrb[0]) begin
                            ctrl.irq_enable <= s_axil_wdata[irq_count-1:0];
                        end
                    end
                    reg_irq_pending: begin
                        // Write one to clear
                        if (s_axil_wstrb[0]) begin
                            ctrl.clear_mask <= s_axil_wdata[irq_count-1:0];
                        end
                    end
                    reg_irq_force: begin
                        if (s_axil_wstrb[0]) begin
                            ctrl.force_mask <= s_axil_wdata[irq_count-1:0];
                        end
                    end
                    reg_timer_period: begin
                        if (s_axil_wstrb[0]) begin
                            ctrl.timer_period[7:0] <= s_axil_wdata[7:0];
                        end
                        if (s_axil_wstrb[1]) begin
                            ctrl.timer_period[15:8] <= s_axil_wdata[15:8];
                        end
                    end
                    reg_timer_ctrl: begin
                        if (s_axil_wstrb[0]) begin
                            ctrl.timer_enable <= s_axil_wdata[0];
                        end
                    end
                    reg_block_id: begin
                        // Read-only, write accepted and dropped
                    end
                    default: begin
                        s_axil_bresp <= resp_slverr;
                    end
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        rd_word = '0;
        rd_resp = resp_okay;
        case (s_axil_araddr)
            reg_irq_enable: begin
                rd_word = {{(axil_data_width-irq_count){1'b0}}, ctrl.irq_enable};
            end
            reg_irq_pending: begin
                rd_word = {{(axil_data_width-irq_count){1'b0}}, ctrl.pending};
            end
            reg_irq_force: begin
                // Force is a strobe and reads back as zero
                rd_word = '0;
            end
            reg_timer_period: begin
                rd_word = {{(axil_data_width-timer_width){1'b0}}, ctrl.timer_period};
            end
            reg_timer_ctrl: begin
                rd_word = {{(axil_data_width-1){1'b0}}, ctrl.timer_enable};
            end
            reg_block_id: begin
                rd_word = block_id_value;
            end
            default: begin
                rd_resp = resp_slverr;
            end
        endcase
    end

    // Read handshake, arready held low for the first cycle out of reset
    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            s_axil_rvalid  <= 1'b0;
            s_axil_arready <= 1'b0;
        end else if (rd_accept) begin
            s_axil_rvalid  <= 1'b1;
            s_axil_arready <= 1'b0;
        end else if (s_axil_rvalid && s_axil_rready) begin
            s_axil_rvalid  <= 1'b0;
            s_axil_arready <= 1'b1;
        end else begin
            s_axil_arready <= !s_axil_rvalid;
        end
    end

    // Read payload captured at the address handshake
    always_ff @(posedge zynq_pl_clk) begin
        if (rd_accept) begin
            s_axil_rdata <= rd_word;
            s_axil_rresp <= rd_resp;
        end
    end

endmodule

`default_nettype wire

//--- irq_event_gen.sv
// Period timer, external edge detection, pending register and interrupt pulse generation
`timescale 1ns/1ps
`default_nettype none

module irq_event_gen
    import zynq_pl_irq_pkg::*;
(
    input  logic                 zynq_pl_clk,
    input  logic                 zynq_pl_reset,
    input  logic [irq_count-1:0] ext_event,
    irq_ctrl_if.gen              ctrl,
    output logic [irq_count-1:0] irq_pulse
);

    logic [timer_width-1:0] timer_count;
    logic                   timer_event;
    logic [irq_count-1:1]   ext_prev;
    logic [irq_count-1:1]   ext_rise_q;
    logic [irq_count-1:0]   events;
    logic [irq_count-1:0]   set_mask;

    // Line 0 belongs to the timer, a period of zero never fires
    assign timer_event = ctrl.timer_enable && (ctrl.timer_period != '0) &&
                         (timer_count == ctrl.timer_period);

    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            timer_count <= '0;
        end else if (!ctrl.timer_enable) begin
            timer_count <= '0;
        end else if (timer_count >= ctrl.timer_period) begin
            // Also restarts when the period is lowered below the count
            timer_count <= '0;
        end else begin
            timer_count <= timer_count + 1'b1;
        end
    end

    // Rising edges on lines 1 and up, held one cycle
    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            ext_prev   <= '0;
            ext_rise_q <= '0;
        end else begin
            ext_prev   <= ext_event[irq_count-1:1];
            ext_rise_q <= ext_event[irq_count-1:1] & ~ext_prev;
        end
    end

    assign events = {ext_rise_q, timer_event};

    // Force bypasses the enable
    assign set_mask = (events & ctrl.irq_enable) | ctrl.force_mask;

    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            ctrl.pending <= '0;
            irq_pulse    <= '0;
        end else begin
            // Set wins over a clear in the same cycle
            ctrl.pending <= (ctrl.pending & ~ctrl.clear_mask) | set_mask;
            irq_pulse    <= set_mask;
        end
    end

endmodule

`default_nettype wire

//--- irq_stretch.sv
// Interrupt stretcher holding each line high for a fixed number of cycles after a pulse
`timescale 1ns/1ps
`default_nettype none

module irq_stretch
    import zynq_pl_irq_pkg::*;
(
    input  logic                 zynq_pl_clk,
    input  logic                 zynq_pl_reset,
    input  logic [irq_count-1:0] irq_pulse,
    output logic [irq_count-1:0] zynq_irq
);

    // Stage 0 holds the newest pulse vector
    logic [irq_stretch_len-1:0][irq_count-1:0] history;

    always_ff @(posedge zynq_pl_clk) begin
        if (zynq_pl_reset) begin
            history <= '0;
        end else begin
            history <= {history[irq_stretch_len-2:0], irq_pulse};
        end
    end

    // Any pulse still in the history keeps the line asserted
    always_comb begin
        zynq_irq = '0;
        for (int s = 0; s < irq_stretch_len; s++) begin
            zynq_irq = zynq_irq | history[s];
        end
    end

endmodule

`default_nettype wire

//--- zynq_pl_irq.sv
// PL interrupt block top level with AXI-lite control, event generator and stretcher
`timescale 1ns/1ps
`default_nettype none

module zynq_pl_irq
    import zynq_pl_irq_pkg::*;
(
    input  logic                       zynq_pl_clk,
    input  logic                       zynq_pl_reset,

    input  logic [axil_addr_width-1:0] s_axil_awaddr,
    input  logic                       s_axil_awvalid,
    output logic                       s_axil_awready,
    input  logic [axil_data_width-1:0] s_axil_wdata,
    input  logic [axil_strb_width-1:0] s_axil_wstrb,
    input  logic                       s_axil_wvalid,
    output logic                       s_axil_wready,
    output logic [1:0]                 s_axil_bresp,
    output logic                       s_axil_bvalid,
    input  logic                       s_axil_bready,
    input  logic [axil_addr_width-1:0] s_axil_araddr,
    input  logic                       s_axil_arvalid,
    output logic                       s_axil_arready,
    output logic [axil_data_width-1:0] s_axil_rdata,
    output logic [1:0]                 s_axil_rresp,
    output logic                       s_axil_rvalid,
    input  logic                       s_axil_rready,

    input  logic [irq_count-1:0]       ext_event,
    output logic [irq_count-1:0]       zynq_irq
);

    irq_ctrl_if ctrl ();

    logic [irq_count-1:0] irq_pulse;

    axil_ctrl_regs u_regs (
        .zynq_pl_clk    (zynq_pl_clk),
        .zynq_pl_reset  (zynq_pl_reset),
        .s_axil_awaddr  (s_axil_awaddr),
        .s_axil_awvalid (s_axil_awvalid),
        .s_axil_awready (s_axil_awready),
        .s_axil_wdata   (s_axil_wdata),
        .s_axil_wstrb   (s_axil_wstrb),
        .s_axil_wvalid  (s_axil_wvalid),
        .s_axil_wready  (s_axil_wready),
        .s_axil_bresp   (s_axil_bresp),
        .s_axil_bvalid  (s_axil_bvalid),
        .s_axil_bready  (s_axil_bready),
        .s_axil_araddr  (s_axil_araddr),
        .s_axil_arvalid (s_axil_arvalid),
        .s_axil_arready (s_axil_arready),
        .s_axil_rdata   (s_axil_rdata),
        .s_axil_rresp   (s_axil_rresp),
        .s_axil_rvalid  (s_axil_rvalid),
        .s_axil_rready  (s_axil_rready),
        .ctrl           (ctrl.regs)
    );

    irq_event_gen u_event_gen (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .ext_event     (ext_event),
        .ctrl          (ctrl.gen),
        .irq_pulse     (irq_pulse)
    );

    irq_stretch u_stretch (
        .zynq_pl_clk   (zynq_pl_clk),
        .zynq_pl_reset (zynq_pl_reset),
        .irq_pulse     (irq_pulse),
        .zynq_irq      (zynq_irq)
    );

endmodule

`default_nettype wire

//--- zynq_pl_irq_props.sv
// Bound assertions for the AXI-lite handshake and the interrupt stretcher
`timescale 1ns/1ps
`default_nettype none

module zynq_pl_irq_props
    import zynq_pl_irq_pkg::*;
(
    input logic                 zynq_pl_clk,
    input logic                 zynq_pl_reset,
    input logic                 awready,
    input logic                 bvalid,
    input logic                 bready,
    input logic                 rvalid,
    input logic                 rready,
    input logic [irq_count-1:0] irq_pulse,
    input logic [irq_count-1:0] zynq_irq
);

    bvalid_hold: assert property (@(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        bvalid && !bready |=> bvalid) else $error("bvalid dropped before bready");

    rvalid_hold: assert property (@(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        rvalid && !rready |=> rvalid) else $error("rvalid dropped before rready");

    // A held-off write response keeps the write channel closed
    no_write_while_busy: assert property (@(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
        bvalid && !bready |=> !awready)
        else $error("awready high while the write response is held off");

    // A pulse n cycles back still holds its line
    for (genvar n = 1; n <= irq_stretch_len; n++) begin : g_hold
        stretch_hold: assert property (@(posedge zynq_pl_clk) disable iff (zynq_pl_reset)
            ($past(irq_pulse, n) & ~zynq_irq) == {irq_count{1'b0}})
            else $error("zynq_irq low inside the stretch window");
    end

endmodule

bind zynq_pl_irq zynq_pl_irq_props u_props (
    .zynq_pl_clk(zynq_pl_clk), .zynq_pl_reset(zynq_pl_reset),
    .awready(s_axil_awready), .bvalid(s_axil_bvalid), .bready(s_axil_bready),
    .rvalid(s_axil_rvalid), .rready(s_axil_rready),
    .irq_pulse(irq_pulse), .zynq_irq(zynq_irq)
);

`default_nettype wire

//--- tb_zynq_pl_irq.sv
// Testbench with random AXI-lite and event stimulus, cycle model, compare tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_zynq_pl_irq
    import zynq_pl_irq_pkg::*;
;

    localparam int reset_cycles = 10;
    localparam int num_cycles   = 2000;
    localparam int wait_limit   = 100;

    logic                       zynq_pl_clk;
    logic                       zynq_pl_reset;
    logic [axil_addr_width-1:0] s_axil_awaddr;
    logic                       s_axil_awvalid;
    logic                       s_axil_awready;
    logic [axil_data_width-1:0] s_axil_wdata;
    logic [axil_strb_width-1:0] s_axil_wstrb;
    logic                       s_axil_wvalid;
    logic                       s_axil_wready;
    logic [1:0]                 s_axil_bresp;
    logic                       s_axil_bvalid;
    logic                       s_axil_bready;
    logic [axil_addr_width-1:0] s_axil_araddr;
    logic                       s_axil_arvalid;
    logic                       s_axil_arready;
    logic [axil_data_width-1:0] s_axil_rdata;
    logic [1:0]                 s_axil_rresp;
    logic                       s_axil_rvalid;
    logic                       s_axil_rready;
    logic [irq_count-1:0]       ext_event;
    logic [irq_count-1:0]       zynq_irq;

    // Reference model state
    logic [irq_count-1:0]       m_enable;
    logic [irq_count-1:0]       m_clear;
    logic [irq_count-1:0]       m_force;
    logic [irq_count-1:0]       m_pending;
    logic [irq_count-1:0]       m_pulse;
    logic [irq_count-1:1]       m_prev;
    logic [irq_count-1:1]       m_rise;
    logic [timer_width-1:0]     m_period;
    logic [timer_width-1:0]     m_count;
    logic                       m_ten;
    logic                       m_bvalid;
    logic                       m_rvalid;
    logic                       m_arready;
    logic                       m_wr_acc;
    logic                       m_rd_acc;
    logic [1:0]                 m_bresp;
    logic [1:0]                 m_rresp;
    logic [axil_data_width-1:0] m_rdata;
    int                         m_hold [irq_count];
    int                         wr_wait = 0;
    int                         rd_wait = 0;

    zynq_pl_irq dut (.*);

    always #4 zynq_pl_clk = ~zynq_pl_clk;

    task automatic stop_run();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_resp(string name, logic [1:0] expected, logic [1:0] got);
        if (got !== expected) begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, expected, got);
            stop_run();
        end
    endtask

    task automatic check_data(string name, logic [axil_data_width-1:0] expected,
                              logic [axil_data_width-1:0] got);
        if (got !== expected) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, expected, got);
            stop_run();
        end
    endtask

    task automatic check_irq(string name, logic [irq_count-1:0] expected,
                             logic [irq_count-1:0] got);
        if (got !== expected) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, got);
            stop_run();
        end
    endtask

    task automatic check_flag(string name, logic expected, logic got);
        if (got !== expected) begin
            $display("mismatch at %0t: %s expected %b got %b", $time, name, expected, got);
            stop_run();
        end
    endtask

    // Mostly mapped offsets, some unmapped and some fully random
    function automatic logic [axil_addr_width-1:0] pick_offset(logic [31:0] r);
        case (r[2:0])
            3'd0: return reg_irq_enable;
            3'd1: return reg_irq_pending;
            3'd2: return reg_irq_force;
            3'd3: return reg_timer_period;
            3'd4: return reg_timer_ctrl;
            3'd5: return reg_block_id;
            3'd6: return 8'h18;
            default: return r[15:8];
        endcase
    endfunction

    // One clock edge of the model, all next values from the state before the edge
    task automatic model_step();
        logic [irq_count-1:0] set_mask;
        logic                 timer_hit;
        if (zynq_pl_reset) begin
            m_enable  = '0;
            m_clear   = '0;
            m_force   = '0;
            m_pending = '0;
            m_pulse   = '0;
            m_prev    = '0;
            m_rise    = '0;
            m_period  = '0;
            m_count   = '0;
            m_ten     = 1'b0;
            m_bvalid  = 1'b0;
            m_rvalid  = 1'b0;
            m_arready = 1'b0;
            m_wr_acc  = 1'b0;
            m_rd_acc  = 1'b0;
            foreach (m_hold[k]) m_hold[k] = 0;
        end else begin
            m_rd_acc = s_axil_arvalid && m_arready;
            if (m_rd_acc) begin
                m_rresp = resp_okay;
                m_rdata = '0;
                case (s_axil_araddr)
                    reg_irq_enable:   m_rdata[irq_count-1:0] = m_enable;
                    reg_irq_pending:  m_rdata[irq_count-1:0] = m_pending;
                    reg_irq_force:    m_rdata = '0;
                    reg_timer_period: m_rdata[timer_width-1:0] = m_period;
                    reg_timer_ctrl:   m_rdata[0] = m_ten;
                    reg_block_id:     m_rdata = block_id_value;
                    default:          m_rresp = resp_slverr;
                endcase
            end
            m_rvalid  = m_rd_acc || (m_rvalid && !s_axil_rready);
            m_arready = !m_rvalid;

            timer_hit = m_ten && (m_period != '0) && (m_count == m_period);
            set_mask  = ({m_rise, timer_hit} & m_enable) | m_force;
            foreach (m_hold[k]) begin
                if (m_pulse[k]) m_hold[k] = irq_stretch_len;
                else if (m_hold[k] > 0) m_hold[k] = m_hold[k] - 1;
            end
            m_pulse   = set_mask;
            m_pending = (m_pending & ~m_clear) | set_mask;
            m_count   = (!m_ten || m_count >= m_period) ? '0 : m_count + 1'b1;
            m_rise    = ext_event[irq_count-1:1] & ~m_prev;
            m_prev    = ext_event[irq_count-1:1];

            // Register writes land on the handshake edge
            m_wr_acc = s_axil_awvalid && s_axil_wvalid && !m_bvalid;
            m_bvalid = m_wr_acc || (m_bvalid && !s_axil_bready);
            m_clear  = '0;
            m_force  = '0;
            if (m_wr_acc) begin
                m_bresp = resp_okay;
                case (s_axil_awaddr)
                    reg_irq_enable:  if (s_axil_wstrb[0]) m_enable = s_axil_wdata[irq_count-1:0];
                    reg_irq_pending: if (s_axil_wstrb[0]) m_clear = s_axil_wdata[irq_count-1:0];
                    reg_irq_force:   if (s_axil_wstrb[0]) m_force = s_axil_wdata[irq_count-1:0];
                    reg_timer_period: begin
                        if (s_axil_wstrb[0]) m_period[7:0] = s_axil_wdata[7:0];
                        if (s_axil_wstrb[1]) m_period[15:8] = s_axil_wdata[15:8];
                    end
                    reg_timer_ctrl:  if (s_axil_wstrb[0]) m_ten = s_axil_wdata[0];
                    reg_block_id:    m_bresp = resp_okay;
                    default:         m_bresp = resp_slverr;
                endcase
            end
        end
    endtask

    task automatic compare_outputs();
        logic [irq_count-1:0] irq_exp;
        logic                 wr_ready_exp;
        foreach (m_hold[k]) irq_exp[k] = m_hold[k] > 0;
        // Write channels ready only with both valids and no response outstanding
        wr_ready_exp = s_axil_awvalid && s_axil_wvalid && !m_bvalid;
        check_irq("zynq_irq", irq_exp, zynq_irq);
        check_irq("pending", m_pending, dut.ctrl.pending);
        check_flag("s_axil_awready", wr_ready_exp, s_axil_awready);
        check_flag("s_axil_wready", wr_ready_exp, s_axil_wready);
        check_flag("s_axil_arready", m_arready, s_axil_arready);
        check_flag("s_axil_bvalid", m_bvalid, s_axil_bvalid);
        check_flag("s_axil_rvalid", m_rvalid, s_axil_rvalid);
        if (m_bvalid) check_resp("s_axil_bresp", m_bresp, s_axil_bresp);
        if (m_rvalid) begin
            check_resp("s_axil_rresp", m_rresp, s_axil_rresp);
            check_data("s_axil_rdata", m_rdata, s_axil_rdata);
        end
    endtask

    task automatic drive_master();
        logic [31:0] r;
        r = $urandom();
        if (m_wr_acc) begin
            s_axil_awvalid = 1'b0;
            s_axil_wvalid  = 1'b0;
        end
        if (!s_axil_awvalid && r[1:0] == 2'd0) begin
            s_axil_awaddr = pick_offset($urandom());
            s_axil_wdata  = $urandom();
            s_axil_wstrb  = (r[3:2] == 2'd0) ? r[7:4] : 4'hF;
            // Short periods keep the timer busy, bit 8 still reaches the upper byte
            if (s_axil_awaddr == reg_timer_period) begin
                s_axil_wdata[15:9] = '0;
                s_axil_wdata[7:5]  = '0;
            end
            s_axil_awvalid = 1'b1;
            s_axil_wvalid  = 1'b1;
        end
        if (m_rd_acc) s_axil_arvalid = 1'b0;
        if (!s_axil_arvalid && r[9:8] == 2'd0) begin
            s_axil_araddr  = pick_offset($urandom());
            s_axil_arvalid = 1'b1;
        end
        s_axil_bready = r[11:10] != 2'd0;
        s_axil_rready = r[13:12] != 2'd0;
        if (r[16:14] == 3'd0) ext_event = ext_event ^ (irq_count'(1) << r[19:17]);
    endtask

    initial begin
        int seed;
        seed           = $urandom(65377);
        zynq_pl_clk    = 1'b0;
        zynq_pl_reset  = 1'b1;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        ext_event      = '0;
        for (int cycle = 0; cycle < reset_cycles + num_cycles; cycle++) begin
            @(posedge zynq_pl_clk);
            model_step();
            @(negedge zynq_pl_clk);
            compare_outputs();
            if (cycle >= reset_cycles - 1) begin
                zynq_pl_reset = 1'b0;
                drive_master();
            end
            wr_wait = s_axil_awvalid ? wr_wait + 1 : 0;
            rd_wait = s_axil_arvalid ? rd_wait + 1 : 0;
            if (wr_wait > wait_limit || rd_wait > wait_limit) begin
                $display("AXI-lite request not accepted within %0d cycles", wait_limit);
                stop_run();
            end
        end
        $display("Simulation PASSED");
        $finish;
    end

    // Twenty times the sequence length
    initial begin
        repeat ((reset_cycles + num_cycles) * 20) @(posedge zynq_pl_clk);
        $display("timeout: test sequence did not end in time");
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- zynq_pl_irq.f
zynq_pl_irq_pkg.sv
irq_ctrl_if.sv
axil_ctrl_regs.sv
irq_event_gen.sv
irq_stretch.sv
zynq_pl_irq.sv
zynq_pl_irq_props.sv
tb_zynq_pl_irq.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator, verdict from the log
set -u
set -o pipefail
cd "$(dirname "$0")" || exit 1
log=sim.log

if ! verilator --binary --assert --top-module tb_zynq_pl_irq -f zynq_pl_irq.f \
        -o sim_zynq_pl_irq; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_zynq_pl_irq 2>&1 | tee "$log"
run_status=$?

if grep -q "Simulation FAILED" "$log"; then
    echo "run failed, see $log"
    exit 1
fi
if [ "$run_status" -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi
echo "run passed"
exit 0
